//--- source/u110Pkg.sv
/*
 * shared constants for the U110 cycle termination corner.
 * local bus address and region widths, default region codes,
 * ATA wait-state limit and the terminator state encoding.
 */

package u110Pkg;

    // ------------------------------------------------------------
    // local bus address
    // ------------------------------------------------------------
    localparam int ADDR_W   = 32;  // 68040 address bus width.
    localparam int REGION_W = 8;   // top address bits that pick a region.

    // default region codes, compared against addr[31:24].
    localparam logic [REGION_W-1:0] ATA_REGION_DEFAULT = 8'hDA; // ATA register space.
    localparam logic [REGION_W-1:0] PCI_REGION_DEFAULT = 8'h40; // PCI window.

    // ------------------------------------------------------------
    // ATA wait states
    // ------------------------------------------------------------
    // largest wait-state count the timer can hold.
    // 15 keeps the counter at 4 bits.
    localparam int ATA_WAIT_MAX = 15;

    // ------------------------------------------------------------
    // terminator state encoding
    // ------------------------------------------------------------
    // idle covers both armed and waiting for ready to drop,
    // the arm flag tells them apart.
    typedef enum logic [1:0] {
        TERM_IDLE    = 2'b00,  // no pulse in progress.
        TERM_ASSERT  = 2'b01,  // TACKn driven low.
        TERM_RELEASE = 2'b10   // TACKn driven high, still enabled.
    } termState_t;

endpackage

//--- source/addressDecode.sv
/*
 * address decoder for the local bus.
 * latches a transfer start and classifies it as ATA, PCI or foreign.
 * the selection holds until TACKn is seen driven low.
 */

`timescale 1ns/1ps

module addressDecode
    import u110Pkg::*;
#(
    parameter logic [REGION_W-1:0] ataRegion = ATA_REGION_DEFAULT, // ATA space code.
    parameter logic [REGION_W-1:0] pciRegion = PCI_REGION_DEFAULT  // PCI space code.
) (
    input  logic              CLK40,   // 40 MHz bus clock.
    input  logic              RESETn,  // synchronous, active low.
    input  logic              tsN,     // transfer start, one cycle low.
    input  logic [ADDR_W-1:0] addr,    // bus address, valid with tsN.
    input  logic              tackN,   // acknowledge value from the terminator.
    input  logic              tackOe,  // acknowledge output enable.
    output logic              ataSel,  // ATA cycle in flight.
    output logic              pciSel   // PCI cycle in flight.
);

    // ------------------------------------------------------------
    // region compare
    // ------------------------------------------------------------
    logic [REGION_W-1:0] region;    // top bits of the address.
    logic                cycleBusy; // a cycle is still selected.
    logic                tackSeen;  // acknowledge driven low on the bus.
    logic                startOk;   // accepted transfer start.

    assign region    = addr[ADDR_W-1 -: REGION_W];
    assign cycleBusy = ataSel | pciSel;
    assign tackSeen  = ~tackN & tackOe;   // only our own drive counts.

    // one cycle in flight, an overlapping start is dropped.
    assign startOk = ~tsN & ~cycleBusy;

    // ------------------------------------------------------------
    // selection registers
    // ------------------------------------------------------------
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            ataSel <= 1'b0;
            pciSel <= 1'b0;
        end else begin
            if (cycleBusy) begin
                // hold until the pulse is on the bus.
                if (tackSeen) begin
                    ataSel <= 1'b0;
                    pciSel <= 1'b0;
                end
            end else if (startOk) begin
                // foreign space sets neither, another device answers.
                ataSel <= (region == ataRegion);
                pciSel <= (region == pciRegion);
            end
        end
    end

endmodule

//--- source/ataCycleTimer.sv
/*
 * ATA wait-state timer.
 * counts rising edges of a selected ATA cycle and raises the
 * ATA ready level once the wait states have passed.
 */

`timescale 1ns/1ps

module ataCycleTimer
    import u110Pkg::*;
#(
    parameter int unsigned ataWaitStates = 3  // wait states per ATA cycle.
) (
    input  logic CLK40,   // 40 MHz bus clock.
    input  logic RESETn,  // synchronous, active low.
    input  logic ataSel,  // ATA cycle selected by the decoder.
    output logic ataTack  // ATA ready level to the terminator.
);

    // ------------------------------------------------------------
    // counter sizing
    // ------------------------------------------------------------
    localparam int CNT_W = $clog2(ATA_WAIT_MAX + 1);          // 4 bits for 15.
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(ataWaitStates);
    localparam logic             NO_WAIT   = (ataWaitStates == 0);

    logic [CNT_W-1:0] waitCount;  // edges counted so far.
    logic             ataSelD;    // ataSel one edge back.
    logic             selRise;    // first edge of a new cycle.

    assign selRise = ataSel & ~ataSelD;

    // ------------------------------------------------------------
    // wait-state counter
    // ------------------------------------------------------------
    // edge 0 samples tsN, ataSel is seen high at edge 1.
    // ataTack rises at edge W+1, so the count reaches W one edge before.
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            ataSelD   <= 1'b0;
            waitCount <= '0;
            ataTack   <= 1'b0;
        end else begin
            ataSelD <= ataSel;

            if (!ataSel) begin
                // cycle over, clear so the terminator re-arms.
                waitCount <= '0;
                ataTack   <= 1'b0;
            end else if (selRise) begin
                waitCount <= CNT_W'(1);  // load on the first selected edge.
                ataTack   <= NO_WAIT;    // zero waits is ready at once.
            end else if (!ataTack) begin
                if (waitCount == WAIT_LAST) begin
                    ataTack <= 1'b1;     // hold until ataSel drops.
                end else begin
                    waitCount <= waitCount + CNT_W'(1);
                end
            end
        end
    end

endmodule

//--- source/cycleTermination.sv
/*
 * cycle termination for ATA and PCI transfers.
 * falling-edge FSM that pulses TACKn low for one clock with
 * cache-inhibit, burst-inhibit on ATA cycles, and a one clock release.
 */

`timescale 1ns/1ps

module cycleTermination
    import u110Pkg::*;
(
    input  logic CLK40,   // 40 MHz bus clock.
    input  logic RESETn,  // synchronous, active low.
    input  logic ataTack, // ready level from the ATA timer.
    input  logic pciAck,  // ready level from the PCI bridge.
    input  logic ataSel,  // ATA cycle selected.
    output logic tackN,   // transfer acknowledge value.
    output logic tciN,    // cache inhibit value, enabled by tackOe.
    output logic tbiN,    // burst inhibit value.
    output logic teaN,    // transfer error value.
    output logic tackOe,  // enable for TACKn and TCIn.
    output logic tbiOe    // enable for TBIn.
);

    // ------------------------------------------------------------
    // pulse FSM
    // ------------------------------------------------------------
    termState_t state;  // current step of the pulse.
    logic       armed;  // ready has been low since the last pulse.
    logic       ready;  // either source asks for termination.

    assign ready = ataTack | pciAck;

    // outputs change on the falling edge so the CPU samples them clean
    // on the following rising edge.
    always_ff @(negedge CLK40) begin
        if (!RESETn) begin
            state  <= TERM_IDLE;
            armed  <= 1'b1;
            tackN  <= 1'b1;
            tackOe <= 1'b0;
            tbiOe  <= 1'b0;
        end else begin
            case (state)
                TERM_IDLE: begin
                    if (ready && armed) begin
                        state  <= TERM_ASSERT;
                        tackN  <= 1'b0;    // acknowledge.
                        tackOe <= 1'b1;
                        tbiOe  <= ataSel;  // no bursts into ATA space.
                        armed  <= 1'b0;    // one pulse per ready.
                    end else if (!ready) begin
                        armed <= 1'b1;
                    end
                end
                TERM_ASSERT: begin
                    tackN <= 1'b1;         // drive high before release.
                    state <= TERM_RELEASE;
                end
                TERM_RELEASE: begin
                    tackOe <= 1'b0;        // let go of the bus.
                    tbiOe  <= 1'b0;
                    state  <= TERM_IDLE;
                end
                default: begin
                    state <= TERM_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // inhibit and error values
    // ------------------------------------------------------------
    assign tciN = tackN;                    // never cache PCI or ATA space.
    assign tbiN = tbiOe ? tackN : 1'b1;
    assign teaN = 1'b1;                     // no bus errors from here.

endmodule

//--- source/u110Top.sv
/*
 * top level of the U110 cycle termination corner.
 * address decoder, ATA wait-state timer and terminator.
 */

`timescale 1ns/1ps

module u110Top
    import u110Pkg::*;
#(
    parameter logic [REGION_W-1:0] ataRegion     = ATA_REGION_DEFAULT, // ATA space code.
    parameter logic [REGION_W-1:0] pciRegion     = PCI_REGION_DEFAULT, // PCI space code.
    parameter int unsigned         ataWaitStates = 3                   // ATA wait states.
) (
    input  logic              CLK40,   // 40 MHz bus clock.
    input  logic              RESETn,  // synchronous, active low.
    input  logic              tsN,     // transfer start.
    input  logic [ADDR_W-1:0] addr,    // bus address.
    input  logic              pciAck,  // ready from the PCI bridge.
    output logic              tackN,   // transfer acknowledge.
    output logic              tciN,    // cache inhibit.
    output logic              tbiN,    // burst inhibit.
    output logic              teaN,    // transfer error.
    output logic              tackOe,  // enable for TACKn and TCIn.
    output logic              tbiOe    // enable for TBIn.
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    logic ataSel;   // ATA cycle in flight.
    logic pciSel;   // PCI cycle in flight.
    logic ataTack;  // ATA wait states done.

    // classify the transfer start.
    addressDecode #(
        .ataRegion (ataRegion),
        .pciRegion (pciRegion)
    ) i_addressDecode (
        .CLK40  (CLK40),
        .RESETn (RESETn),
        .tsN    (tsN),
        .addr   (addr),
        .tackN  (tackN),   // fed back to end the cycle.
        .tackOe (tackOe),
        .ataSel (ataSel),
        .pciSel (pciSel)
    );

    // wait states for ATA cycles.
    ataCycleTimer #(
        .ataWaitStates (ataWaitStates)
    ) i_ataCycleTimer (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .ataSel  (ataSel),
        .ataTack (ataTack)
    );

    // pciSel has no reader past the decoder, PCI ready comes from pciAck.
    cycleTermination i_cycleTermination (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .ataTack (ataTack),
        .pciAck  (pciAck),
        .ataSel  (ataSel),
        .tackN   (tackN),
        .tciN    (tciN),
        .tbiN    (tbiN),
        .teaN    (teaN),
        .tackOe  (tackOe),
        .tbiOe   (tbiOe)
    );

endmodule

//--- dv/cycleTermination_sva.sv
/*
 * bound assertions for the cycle terminator.
 * TACKn pulse width, release timing, enable pairing and a quiet TEAn.
 */

`timescale 1ns/1ps

module cycleTermination_sva (
    input logic CLK40,   // bus clock.
    input logic RESETn,  // synchronous, active low.
    input logic tackN,
    input logic tackOe,
    input logic tbiOe,
    input logic teaN
);

    // ------------------------------------------------------------
    // pulse shape
    // ------------------------------------------------------------
    // outputs move on the falling edge, rising edge sees them settled.
    tackOneClock: assert property (@(posedge CLK40) disable iff (!RESETn)
        !tackN |=> tackN)
        else $error("TACKn stayed low for more than one clock");

    releaseAfterTack: assert property (@(posedge CLK40) disable iff (!RESETn)
        $rose(tackN) |=> $fell(tackOe))
        else $error("output enable did not drop one clock after TACKn rose");

    // ------------------------------------------------------------
    // enables and error
    // ------------------------------------------------------------
    tackDriven: assert property (@(posedge CLK40) disable iff (!RESETn)
        !tackN |-> tackOe)
        else $error("TACKn low while not driven");

    tbiWithTack: assert property (@(posedge CLK40) disable iff (!RESETn)
        tbiOe |-> tackOe)
        else $error("burst inhibit driven outside an acknowledge");

    teaQuiet: assert property (@(posedge CLK40) disable iff (!RESETn)
        teaN)
        else $error("TEAn went low");

endmodule

bind cycleTermination cycleTermination_sva i_termSva (
    .CLK40  (CLK40),
    .RESETn (RESETn),
    .tackN  (tackN),
    .tackOe (tackOe),
    .tbiOe  (tbiOe),
    .teaN   (teaN)
);

//--- dv/tbU110.sv
/*
 * testbench for the U110 cycle termination corner.
 * random ATA, PCI and foreign bus cycles from a fixed seed,
 * a cycle model for pulse timing and burst-inhibit, and a pulse monitor.
 */

`timescale 1ns/1ps

module tbU110
    import u110Pkg::*;
();

    // ------------------------------------------------------------
    // settings and signals
    // ------------------------------------------------------------
    localparam int WAIT_STATES  = 3;    // ATA wait states given to the DUT.
    localparam int CYCLES       = 200;  // random bus cycles.
    localparam int PULSE_LIMIT  = 40;   // rising edges allowed per cycle.
    localparam int KIND_ATA     = 0;
    localparam int KIND_PCI     = 1;
    localparam int KIND_FOREIGN = 2;

    logic              CLK40;
    logic              RESETn;
    logic              tsN;
    logic [ADDR_W-1:0] addr;
    logic              pciAck;   // driven as the PCI bridge.
    logic              tackN;
    logic              tciN;
    logic              tbiN;
    logic              teaN;
    logic              tackOe;
    logic              tbiOe;

    integer seed      = 32'hb814aad4;  // fixed seed for $random.
    logic   lastTackN = 1'b1;          // monitor history.
    logic   expBiQ[$];                 // model: tbiOe per pulse, in order.
    logic   seenBiQ[$];                // monitor: tbiOe per pulse seen.

    u110Top #(
        .ataRegion     (ATA_REGION_DEFAULT),
        .pciRegion     (PCI_REGION_DEFAULT),
        .ataWaitStates (WAIT_STATES)
    ) i_dut (
        .CLK40  (CLK40),
        .RESETn (RESETn),
        .tsN    (tsN),
        .addr   (addr),
        .pciAck (pciAck),
        .tackN  (tackN),
        .tciN   (tciN),
        .tbiN   (tbiN),
        .teaN   (teaN),
        .tackOe (tackOe),
        .tbiOe  (tbiOe)
    );

    initial begin
        CLK40 = 1'b0;
        forever #50 CLK40 = ~CLK40;  // 100 ns period.
    end

    // ------------------------------------------------------------
    // checking
    // ------------------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s got %0h expected %0h",
                              $time, name, got, exp));
        end
    endtask

    // all bus outputs against one expected bus state.
    task automatic expectBus(input logic expTackN, input logic expOe, input logic expBiOe);
        checkValue("tackN", 32'(tackN), 32'(expTackN));
        checkValue("tciN", 32'(tciN), 32'(expTackN));       // inhibit rides with TACKn.
        checkValue("tackOe", 32'(tackOe), 32'(expOe));
        checkValue("tbiOe", 32'(tbiOe), 32'(expBiOe));
        checkValue("tbiN", 32'(tbiN), 32'(expBiOe ? expTackN : 1'b1));
        checkValue("teaN", 32'(teaN), 32'd1);
    endtask

    // counts pulses on its own, so stray pulses in gaps show up too.
    always @(posedge CLK40) begin
        if (RESETn && !tackN && tackOe && lastTackN) begin
            seenBiQ.push_back(tbiOe);
        end
        lastTackN = tackN;
    end

    // ------------------------------------------------------------
    // one bus cycle with its model
    // ------------------------------------------------------------
    // edge 0 is the rising edge that samples tsN low, n counts edges after it.
    task automatic runCycle(input int kind, input bit overlap, input int pciDelay);
        logic [31:0]         rnd;
        logic [REGION_W-1:0] code;
        int                  expectAt;  // edge where TACKn is first seen low.
        int                  lowAt;     // edge where it was seen, 0 for none.
        int                  limit;
        int                  n;
        bit                  expBi;
        bit                  done;

        rnd = $random(seed);
        if (kind == KIND_ATA) begin
            code = ATA_REGION_DEFAULT;
        end else if (kind == KIND_PCI) begin
            code = PCI_REGION_DEFAULT;
        end else begin
            code = rnd[ADDR_W-1 -: REGION_W];
            if (code == ATA_REGION_DEFAULT || code == PCI_REGION_DEFAULT) begin
                code = code ^ 8'h80;        // steer clear of both regions.
            end
        end
        expBi    = (kind == KIND_ATA);      // burst-inhibit only for ATA.
        expectAt = (kind == KIND_ATA) ? WAIT_STATES + 2 :
                   (kind == KIND_PCI) ? pciDelay + 2 : 0;
        limit    = (kind == KIND_FOREIGN) ? WAIT_STATES + 10 : PULSE_LIMIT;
        lowAt    = 0;
        done     = 1'b0;

        @(negedge CLK40);
        tsN  <= 1'b0;
        addr <= {code, rnd[ADDR_W-REGION_W-1:0]};
        if (kind != KIND_FOREIGN) begin
            expBiQ.push_back(expBi);
        end
        @(posedge CLK40);                   // edge 0.

        for (n = 1; n <= limit && !done; n++) begin
            @(negedge CLK40);
            if (n == 1) begin
                // decoder registered the start at edge 0.
                checkValue("ataSel", 32'(i_dut.ataSel), 32'(kind == KIND_ATA));
                checkValue("pciSel", 32'(i_dut.pciSel), 32'(kind == KIND_PCI));
            end
            tsN <= !(overlap && n == 1);    // a second start on a busy cycle.
            if (overlap && n == 1) begin
                addr <= $random(seed);
            end
            if (kind == KIND_PCI) begin
                if (lowAt != 0) begin
                    pciAck <= 1'b0;         // acknowledge seen, drop ready.
                end else if (n == pciDelay + 1) begin
                    pciAck <= 1'b1;
                end
            end

            @(posedge CLK40);
            if (lowAt == 0 && !tackN) begin
                lowAt = n;
                checkValue("TACKn edge", n, expectAt);
            end
            if (lowAt == 0) begin
                expectBus(1'b1, 1'b0, 1'b0);   // quiet until the pulse.
            end else if (n == lowAt) begin
                expectBus(1'b0, 1'b1, expBi);
            end else if (n == lowAt + 1) begin
                expectBus(1'b1, 1'b1, expBi);  // driven high before release.
            end else begin
                expectBus(1'b1, 1'b0, 1'b0);   // bus let go.
                done = 1'b1;
            end
        end

        if (kind != KIND_FOREIGN && lowAt == 0) begin
            failRun("no acknowledge pulse came within the timeout");
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int kind;
        bit overlap;
        int pciDelay;
        int gap;
        int k;

        RESETn <= 1'b0;
        tsN    <= 1'b1;
        addr   <= '0;
        pciAck <= 1'b0;
        repeat (3) @(posedge CLK40);        // reset for 3 cycles.
        @(negedge CLK40);
        checkValue("ataSel", 32'(i_dut.ataSel), 32'd0);
        checkValue("pciSel", 32'(i_dut.pciSel), 32'd0);
        checkValue("ataTack", 32'(i_dut.ataTack), 32'd0);
        RESETn <= 1'b1;
        @(posedge CLK40);
        expectBus(1'b1, 1'b0, 1'b0);        // reset values on the bus.

        for (k = 0; k < CYCLES; k++) begin
            kind     = $unsigned($random(seed)) % 3;
            overlap  = (kind != KIND_FOREIGN) && ($unsigned($random(seed)) % 4 == 0);
            pciDelay = $unsigned($random(seed)) % 6;
            gap      = $unsigned($random(seed)) % 4;
            runCycle(kind, overlap, pciDelay);
            repeat (gap) @(negedge CLK40);  // idle bus between cycles.
        end
        repeat (4) @(negedge CLK40);

        // count and order of all pulses.
        checkValue("pulse count", seenBiQ.size(), expBiQ.size());
        for (k = 0; k < expBiQ.size(); k++) begin
            checkValue("tbiOe of pulse", 32'(seenBiQ[k]), 32'(expBiQ[k]));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- flist.f
source/u110Pkg.sv
source/addressDecode.sv
source/ataCycleTimer.sv
source/cycleTermination.sv
source/u110Top.sv
dv/cycleTermination_sva.sv
dv/tbU110.sv

//--- run.sh
#!/bin/sh
# build and run the U110 testbench with Verilator.
# the exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module tbU110 \
    -f flist.f \
    --Mdir obj_dir \
    -o simU110
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/simU110
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
